// ==== dv/csi2_rx_model.svh ====
typedef enum logic [1:0] {EV_FS, EV_FE, EV_FIXED, EV_ERR} ev_e;

typedef struct packed {
  pix_t [PIX_PER_GRP-1:0] pix;
  logic                   first;
  logic                   last;
} grp_exp_t;

localparam int HDR_BITS = HDR_DATA_W + ECC_W;  // Header bits covered by the code.

logic [WORD_W:0]   stim_q[$];  // Valid flag above the word.
logic [WORD_W-1:0] pay_q[$];
grp_exp_t          exp_grp_q[$];
ev_e               frame_ev_q[$];
ev_e               hdr_ev_q[$];
int                single_flips = 0;

function automatic logic [WORD_W-1:0] make_header(input logic [DT_W-1:0] dt, input int wc,
                                                  input int n_err);
  logic [HDR_DATA_W-1:0] data;
  logic [ECC_W-1:0]      ecc;
  logic [WORD_W-1:0]     w;
  int                    pos;
  data = {WC_W'(wc), 2'b00, dt};
  ecc  = '0;
  for (int i = 0; i < HDR_DATA_W; i++)
  begin
    if (data[i])
      ecc = ecc ^ ECC_SYND_TABLE[i];
  end
  w   = {2'b00, ecc, data};
  pos = rand_below(HDR_BITS);
  if (n_err == 1)
  begin
    // Single flips alternate between data and parity bits.
    pos = (single_flips % 2 != 0) ? HDR_DATA_W + pos % ECC_W : pos % HDR_DATA_W;
    single_flips++;
  end
  if (n_err > 0)
    w[pos] = ~w[pos];
  if (n_err > 1)
  begin
    pos    = (pos + 1 + rand_below(HDR_BITS - 1)) % HDR_BITS;  // Never the first bit again.
    w[pos] = ~w[pos];
  end
  return w;
endfunction

task automatic add_packet(input logic [DT_W-1:0] dt, input int wc, input int n_err);
  int gap;
  stim_q.push_back({1'b1, make_header(dt, wc, n_err)});
  foreach (pay_q[i])
    stim_q.push_back({1'b1, pay_q[i]});
  pay_q.delete();
  gap = 1 + rand_below(3);
  repeat (gap)
    stim_q.push_back({1'b0, {WORD_W{1'b0}}});
  if (n_err == 1)
    hdr_ev_q.push_back(EV_FIXED);
  else if (n_err == 2)
    hdr_ev_q.push_back(EV_ERR);
endtask

task automatic add_short(input csi2_dt_e dt, input int frame_no, input int n_err);
  add_packet(dt, frame_no, n_err);
  if (n_err != 2)
    frame_ev_q.push_back(dt == DT_FS ? EV_FS : EV_FE);
endtask

task automatic add_other(input int n_err);
  int n_words;
  n_words = 1 + rand_below(6);
  repeat (n_words)
    pay_q.push_back(next_rand());
  add_packet(6'h12, 4 * n_words, n_err);  // Generic long type, skipped by the DUT.
endtask

task automatic add_raw10_line(input int wc, input int n_err);
  logic [7:0]  bytes[$];
  logic [7:0]  low;
  logic [31:0] rnd;
  grp_exp_t    g;
  for (int k = 0; k < wc / 5; k++)
  begin
    low = '0;
    for (int i = 0; i < PIX_PER_GRP; i++)
    begin
      rnd      = next_rand();
      g.pix[i] = rnd[PIX_W-1:0];
      bytes.push_back(g.pix[i][PIX_W-1:2]);
      low[2*i +: 2] = g.pix[i][1:0];  // Pixel 0 in the lowest bits.
    end
    bytes.push_back(low);
    g.first = k == 0;
    g.last  = k == wc / 5 - 1;
    if (n_err != 2)
      exp_grp_q.push_back(g);
  end
  for (int j = 0; j < wc / 4; j++)
    pay_q.push_back({bytes[4*j+3], bytes[4*j+2], bytes[4*j+1], bytes[4*j]});
  add_packet(DT_RAW10, wc, n_err);
endtask

// ==== dv/tb_csi2_rx.sv ====
`timescale 1ns/1ps

module tb_csi2_rx;

  import csi2_pkg::*;
  import pixel_pkg::*;

  localparam int N_FRAMES = 6;

  logic              px_clk_i;
  logic              rst_n_i;
  logic [WORD_W-1:0] word_i;
  logic              word_valid_i;
  pix_t              pix_o [PIX_PER_GRP];
  logic              pix_valid_o;
  logic              line_start_o;
  logic              line_end_o;
  logic              frame_start_o;
  logic              frame_end_o;
  logic              hdr_fixed_o;
  logic              hdr_err_o;

  logic [31:0] rng_state = 32'd51690;
  bit          gen_done = 1'b0;
  longint      watchdog_ns;
  int          checks;
  int          pix_errs;
  int          flag_errs;
  int          ev_errs;
  int          misc_errs;

  csi2_rx_core dut (
    .px_clk_i      ( px_clk_i      ),
    .rst_n_i       ( rst_n_i       ),
    .word_i        ( word_i        ),
    .word_valid_i  ( word_valid_i  ),
    .pix_o         ( pix_o         ),
    .pix_valid_o   ( pix_valid_o   ),
    .line_start_o  ( line_start_o  ),
    .line_end_o    ( line_end_o    ),
    .frame_start_o ( frame_start_o ),
    .frame_end_o   ( frame_end_o   ),
    .hdr_fixed_o   ( hdr_fixed_o   ),
    .hdr_err_o     ( hdr_err_o     )
  );

  always #50 px_clk_i = ~px_clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
  endfunction

  `include "csi2_rx_model.svh"

  function automatic int draw_err(input int frame);
    int r;
    r = rand_below(8);
    if (frame == 0)
      return 0;  // First frame stays clean.
    return (r == 0) ? 2 : ((r < 3) ? 1 : 0);
  endfunction

  task automatic check_pix(input string name, input pix_t exp, input pix_t got);
    checks++;
    if (got !== exp)
    begin
      pix_errs++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic got);
    checks++;
    if (got !== exp)
    begin
      flag_errs++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_event(input string name, input ev_e exp, input ev_e got);
    checks++;
    if (got !== exp)
    begin
      ev_errs++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic report_misc(input string msg);
    misc_errs++;
    $display("%s at %0t ns", msg, $time);
  endtask

  task automatic check_group();
    grp_exp_t g;
    if (exp_grp_q.size() == 0)
      report_misc("Pixel group arrived while none was expected");
    else
    begin
      g = exp_grp_q.pop_front();
      for (int i = 0; i < PIX_PER_GRP; i++)
        check_pix($sformatf("pix_o[%0d]", i), g.pix[i], pix_o[i]);
      check_flag("line_start_o", g.first, line_start_o);
      check_flag("line_end_o", g.last, line_end_o);
    end
  endtask

  // Outputs are registered on the rising edge, so the falling edge sees them settled.
  always @(negedge px_clk_i)
  begin
    if (!rst_n_i)
    begin
      check_flag("pix_valid_o", 1'b0, pix_valid_o);
      check_flag("line_start_o", 1'b0, line_start_o);
      check_flag("line_end_o", 1'b0, line_end_o);
      check_flag("frame_start_o", 1'b0, frame_start_o);
      check_flag("frame_end_o", 1'b0, frame_end_o);
      check_flag("hdr_fixed_o", 1'b0, hdr_fixed_o);
      check_flag("hdr_err_o", 1'b0, hdr_err_o);
    end
    else
    begin
      if (pix_valid_o)
        check_group();
      else
      begin
        check_flag("line_start_o", 1'b0, line_start_o);
        check_flag("line_end_o", 1'b0, line_end_o);
      end
      if (frame_start_o || frame_end_o)
      begin
        if (frame_ev_q.size() == 0)
          report_misc("Frame pulse seen while no frame packet was expected");
        else
          check_event("frame_start_o/frame_end_o", frame_ev_q.pop_front(),
                      frame_start_o ? EV_FS : EV_FE);
      end
      if (hdr_fixed_o || hdr_err_o)
      begin
        if (hdr_ev_q.size() == 0)
          report_misc("Header status pulse seen on a header sent without errors");
        else
          check_event("hdr_fixed_o/hdr_err_o", hdr_ev_q.pop_front(),
                      hdr_err_o ? EV_ERR : EV_FIXED);
      end
    end
  end

  // Frame 1 always holds two repairable headers and a rejected FE.
  task automatic build_stimulus();
    int n_lines;
    for (int f = 0; f < N_FRAMES; f++)
    begin
      add_short(DT_FS, f + 1, (f == 1) ? 1 : draw_err(f));
      n_lines = 1 + rand_below(3);
      for (int l = 0; l < n_lines; l++)
      begin
        if (f == 1 || rand_below(4) == 0)
          add_other(draw_err(f));
        add_raw10_line(20 * (1 + rand_below(3)), (f == 1 && l == 0) ? 1 : draw_err(f));
      end
      add_short(DT_FE, f + 1, (f == 1) ? 2 : draw_err(f));
    end
  endtask

  task automatic print_summary();
    $display("Checks %0d, errors %0d: pixel %0d, flag %0d, event %0d, other %0d",
             checks, pix_errs + flag_errs + ev_errs + misc_errs,
             pix_errs, flag_errs, ev_errs, misc_errs);
  endtask

  initial
  begin
    px_clk_i     = 1'b0;
    rst_n_i      = 1'b0;
    word_i       = '0;
    word_valid_i = 1'b0;
    build_stimulus();
    watchdog_ns = longint'(stim_q.size()) * 4 * 100 + 20000;  // Plus reset and drain.
    gen_done    = 1'b1;
    repeat (3) @(posedge px_clk_i);
    #10;
    rst_n_i = 1'b1;
    foreach (stim_q[i])
    begin
      @(posedge px_clk_i);
      #10;
      word_valid_i = stim_q[i][WORD_W];
      word_i       = stim_q[i][WORD_W-1:0];
    end
    @(posedge px_clk_i);
    #10;
    word_valid_i = 1'b0;
    while (exp_grp_q.size() != 0 || frame_ev_q.size() != 0 || hdr_ev_q.size() != 0)
      @(posedge px_clk_i);
    repeat (10) @(posedge px_clk_i);  // Catch stray pulses after the last packet.
    print_summary();
    if (pix_errs + flag_errs + ev_errs + misc_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    wait (gen_done);
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns with %0d pixel groups still expected",
             watchdog_ns, exp_grp_q.size());
    print_summary();
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== hw/csi2_header_ecc.sv ====
`timescale 1ns/1ps

module csi2_header_ecc (
  input  logic                        px_clk_i,
  input  logic                        rst_n_i,
  input  logic [csi2_pkg::WORD_W-1:0] word_i,
  input  logic                        word_valid_i,
  output logic [csi2_pkg::WORD_W-1:0] word_o,
  output logic                        valid_o,
  output logic                        is_hdr_o,
  output logic                        fixed_o,
  output logic                        bad_o
);

  import csi2_pkg::*;

  logic              hdr_now;
  logic [ECC_W-1:0]  synd;
  logic [WORD_W-1:0] hdr_fix;
  logic              synd_hit;
  logic              corr_ok;

  assign hdr_now = word_valid_i && !valid_o;  // First word after an idle cycle.

  // Recomputed parity folded with the received ECC.
  always_comb
  begin
    synd = word_i[HDR_ECC_LSB +: ECC_W];
    for (int i = 0; i < HDR_DATA_W; i++)
    begin
      if (word_i[i])
        synd = synd ^ ECC_SYND_TABLE[i];
    end
  end

  always_comb
  begin
    hdr_fix  = word_i;
    synd_hit = 1'b0;
    for (int i = 0; i < HDR_DATA_W; i++)
    begin
      if (synd == ECC_SYND_TABLE[i])
      begin
        hdr_fix[i] = ~word_i[i];
        synd_hit   = 1'b1;
      end
    end
  end

  // A lone parity bit flip leaves the data bits intact.
  assign corr_ok = synd_hit || $onehot(synd);

  always_ff @(posedge px_clk_i)
  begin
    if (!rst_n_i)
    begin
      valid_o  <= 1'b0;
      is_hdr_o <= 1'b0;
      fixed_o  <= 1'b0;
      bad_o    <= 1'b0;
    end
    else
    begin
      valid_o  <= word_valid_i;
      is_hdr_o <= hdr_now;
      fixed_o  <= hdr_now && (synd != '0) && corr_ok;
      bad_o    <= hdr_now && (synd != '0) && !corr_ok;
    end
  end

  always_ff @(posedge px_clk_i)
  begin
    word_o <= hdr_now ? hdr_fix : word_i;  // Payload passes untouched.
  end

  // A repaired header differs from the received one in at most one bit.
  a_fix_one_bit: assert property (@(posedge px_clk_i) disable iff (!rst_n_i)
    fixed_o |-> ($countones(word_o ^ $past(word_i)) <= 1));

endmodule

// ==== hw/csi2_pkg.sv ====
package csi2_pkg;

  localparam int WORD_W     = 32;
  localparam int ECC_W      = 6;
  localparam int WC_W       = 16;
  localparam int DT_W       = 6;
  localparam int HDR_DATA_W = 24;  // Data identifier plus word count.

  // Bit offsets of the header fields inside the 32-bit word.
  localparam int HDR_DI_LSB  = 0;
  localparam int HDR_WC_LSB  = 8;
  localparam int HDR_ECC_LSB = 24;

  typedef enum logic [DT_W-1:0] {
    DT_FS    = 6'h00,
    DT_FE    = 6'h01,
    DT_RAW10 = 6'h2B
  } csi2_dt_e;

  // Parity bits touched by each header data bit, P5 in the MSB.
  localparam logic [HDR_DATA_W-1:0][ECC_W-1:0] ECC_SYND_TABLE = {
    6'h3B, 6'h37, 6'h2F, 6'h1F,  // D23..D20.
    6'h38, 6'h34, 6'h32, 6'h31,  // D19..D16.
    6'h2C, 6'h2A, 6'h29, 6'h26,
    6'h25, 6'h23, 6'h1C, 6'h1A,
    6'h19, 6'h16, 6'h15, 6'h13,
    6'h0E, 6'h0D, 6'h0B, 6'h07   // D3..D0.
  };

endpackage

// ==== hw/csi2_pkt_parser.sv ====
`timescale 1ns/1ps

module csi2_pkt_parser (
  input  logic                        px_clk_i,
  input  logic                        rst_n_i,
  input  logic [csi2_pkg::WORD_W-1:0] word_i,
  input  logic                        valid_i,
  input  logic                        is_hdr_i,
  input  logic                        bad_i,
  output logic                        frame_start_o,
  output logic                        frame_end_o,
  output logic                        hdr_err_o,
  output logic [csi2_pkg::WORD_W-1:0] pay_word_o,
  output logic                        pay_valid_o,
  output logic                        pay_last_o
);

  import csi2_pkg::*;

  typedef enum logic [1:0] {
    S_HDR,
    S_PAYLOAD,
    S_SKIP,
    S_DROP
  } state_e;

  state_e          state;
  csi2_dt_e        hdr_dt;
  logic [WC_W-1:0] hdr_wc;
  logic [WC_W-3:0] hdr_words;
  logic            hdr_long;
  logic [WC_W-3:0] cnt;
  logic            cnt_end;

  assign hdr_dt    = csi2_dt_e'(word_i[HDR_DI_LSB +: DT_W]);
  assign hdr_wc    = word_i[HDR_WC_LSB +: WC_W];
  assign hdr_words = hdr_wc[WC_W-1:2];  // Four bytes per word.
  assign hdr_long  = word_i[HDR_DI_LSB + 4 +: 2] != 2'b00;  // Types 0x10 and up.
  assign cnt_end   = cnt == 1;

  always_ff @(posedge px_clk_i)
  begin
    if (!rst_n_i)
    begin
      state         <= S_HDR;
      cnt           <= '0;
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      hdr_err_o     <= 1'b0;
      pay_valid_o   <= 1'b0;
      pay_last_o    <= 1'b0;
    end
    else
    begin
      frame_start_o <= 1'b0;
      frame_end_o   <= 1'b0;
      hdr_err_o     <= 1'b0;
      pay_valid_o   <= 1'b0;
      pay_last_o    <= 1'b0;
      if (valid_i && is_hdr_i)
      begin
        if (bad_i)
        begin
          hdr_err_o <= 1'b1;
          state     <= S_DROP;  // Held until the next header.
        end
        else
        begin
          cnt   <= hdr_words;
          state <= S_HDR;
          case (hdr_dt)
            DT_FS:    frame_start_o <= 1'b1;
            DT_FE:    frame_end_o   <= 1'b1;
            DT_RAW10:
            begin
              if (hdr_words != '0)
                state <= S_PAYLOAD;
            end
            default:
            begin
              if (hdr_long && hdr_words != '0)
                state <= S_SKIP;
            end
          endcase
        end
      end
      else if (valid_i && (state == S_PAYLOAD || state == S_SKIP))
      begin
        pay_valid_o <= state == S_PAYLOAD;
        pay_last_o  <= (state == S_PAYLOAD) && cnt_end;
        cnt         <= cnt - 1'b1;
        if (cnt_end)
          state <= S_HDR;
      end
    end
  end

  always_ff @(posedge px_clk_i)
  begin
    if (valid_i)
      pay_word_o <= word_i;
  end

  // Word counts agree with the idle boundaries, so no header cuts into a counted packet.
  a_hdr_boundary: assert property (@(posedge px_clk_i) disable iff (!rst_n_i)
    (valid_i && is_hdr_i) |-> (state == S_HDR || state == S_DROP));

endmodule

// ==== hw/csi2_rx_core.sv ====
`timescale 1ns/1ps

module csi2_rx_core (
  input  logic                        px_clk_i,
  input  logic                        rst_n_i,
  input  logic [csi2_pkg::WORD_W-1:0] word_i,
  input  logic                        word_valid_i,
  output pixel_pkg::pix_t             pix_o [pixel_pkg::PIX_PER_GRP],
  output logic                        pix_valid_o,
  output logic                        line_start_o,
  output logic                        line_end_o,
  output logic                        frame_start_o,
  output logic                        frame_end_o,
  output logic                        hdr_fixed_o,
  output logic                        hdr_err_o
);

  import csi2_pkg::*;
  import pixel_pkg::*;

  logic [WORD_W-1:0] ecc_word;
  logic              ecc_valid;
  logic              ecc_is_hdr;
  logic              hdr_bad;
  logic [WORD_W-1:0] pay_word;
  logic              pay_valid;
  logic              pay_last;
  logic [GRP_W-1:0]  grp;
  logic              grp_valid;
  logic              grp_first;
  logic              grp_last;

  csi2_header_ecc u_ecc (
    .px_clk_i     ( px_clk_i     ),
    .rst_n_i      ( rst_n_i      ),
    .word_i       ( word_i       ),
    .word_valid_i ( word_valid_i ),
    .word_o       ( ecc_word     ),
    .valid_o      ( ecc_valid    ),
    .is_hdr_o     ( ecc_is_hdr   ),
    .fixed_o      ( hdr_fixed_o  ),
    .bad_o        ( hdr_bad      )
  );

  csi2_pkt_parser u_parser (
    .px_clk_i      ( px_clk_i      ),
    .rst_n_i       ( rst_n_i       ),
    .word_i        ( ecc_word      ),
    .valid_i       ( ecc_valid     ),
    .is_hdr_i      ( ecc_is_hdr    ),
    .bad_i         ( hdr_bad       ),
    .frame_start_o ( frame_start_o ),
    .frame_end_o   ( frame_end_o   ),
    .hdr_err_o     ( hdr_err_o     ),
    .pay_word_o    ( pay_word      ),
    .pay_valid_o   ( pay_valid     ),
    .pay_last_o    ( pay_last      )
  );

  raw10_gearbox u_gbx (
    .px_clk_i    ( px_clk_i  ),
    .rst_n_i     ( rst_n_i   ),
    .word_i      ( pay_word  ),
    .valid_i     ( pay_valid ),
    .last_i      ( pay_last  ),
    .grp_o       ( grp       ),
    .grp_valid_o ( grp_valid ),
    .grp_first_o ( grp_first ),
    .grp_last_o  ( grp_last  )
  );

  raw10_unpacker u_unpack (
    .px_clk_i     ( px_clk_i     ),
    .rst_n_i      ( rst_n_i      ),
    .grp_i        ( grp          ),
    .grp_valid_i  ( grp_valid    ),
    .first_i      ( grp_first    ),
    .last_i       ( grp_last     ),
    .pix_o        ( pix_o        ),
    .pix_valid_o  ( pix_valid_o  ),
    .line_start_o ( line_start_o ),
    .line_end_o   ( line_end_o   )
  );

endmodule

// ==== hw/pixel_pkg.sv ====
package pixel_pkg;

  localparam int PIX_W       = 10;
  localparam int PIX_PER_GRP = 4;
  localparam int GRP_W       = PIX_W * PIX_PER_GRP;

  // RAW10 splits each pixel into an upper byte and two low bits.
  localparam int PIX_MSB_W = 8;
  localparam int PIX_LSB_W = PIX_W - PIX_MSB_W;

  // Gearbox residue buffer.
  localparam int GBX_BUF_W  = 72;
  localparam int GBX_FILL_W = $clog2(GBX_BUF_W + 1);

  typedef logic [PIX_W-1:0] pix_t;

endpackage

// ==== hw/raw10_gearbox.sv ====
`timescale 1ns/1ps

module raw10_gearbox (
  input  logic                        px_clk_i,
  input  logic                        rst_n_i,
  input  logic [csi2_pkg::WORD_W-1:0] word_i,
  input  logic                        valid_i,
  input  logic                        last_i,
  output logic [pixel_pkg::GRP_W-1:0] grp_o,
  output logic                        grp_valid_o,
  output logic                        grp_first_o,
  output logic                        grp_last_o
);

  import csi2_pkg::*;
  import pixel_pkg::*;

  logic [GBX_BUF_W-1:0]  buf_q;
  logic [GBX_BUF_W-1:0]  buf_rem;
  logic [GBX_BUF_W-1:0]  buf_d;
  logic [GBX_FILL_W-1:0] fill_q;
  logic [GBX_FILL_W-1:0] fill_rem;
  logic [GBX_FILL_W-1:0] fill_d;
  logic                  drain;
  logic                  first_pend;
  logic                  last_pend;
  logic                  grp_end;

  assign drain    = fill_q >= GBX_FILL_W'(GRP_W);
  assign buf_rem  = drain ? (buf_q >> GRP_W) : buf_q;
  assign fill_rem = drain ? (fill_q - GBX_FILL_W'(GRP_W)) : fill_q;
  assign grp_end  = drain && last_pend && (fill_rem == '0);

  always_comb
  begin
    buf_d  = buf_rem;
    fill_d = fill_rem;
    if (valid_i)
    begin
      buf_d  = buf_rem | (GBX_BUF_W'(word_i) << fill_rem);  // Append above the residue.
      fill_d = fill_rem + GBX_FILL_W'(WORD_W);
    end
  end

  always_ff @(posedge px_clk_i)
  begin
    if (!rst_n_i)
    begin
      buf_q       <= '0;
      fill_q      <= '0;
      first_pend  <= 1'b1;
      last_pend   <= 1'b0;
      grp_valid_o <= 1'b0;
      grp_first_o <= 1'b0;
      grp_last_o  <= 1'b0;
    end
    else
    begin
      buf_q       <= buf_d;
      fill_q      <= fill_d;
      grp_valid_o <= drain;
      grp_first_o <= drain && first_pend;
      grp_last_o  <= grp_end;
      if (drain)
        first_pend <= grp_end;  // Next group opens a new line.
      if (grp_end)
        last_pend <= 1'b0;
      else if (valid_i && last_i)
        last_pend <= 1'b1;
    end
  end

  always_ff @(posedge px_clk_i)
  begin
    if (drain)
      grp_o <= buf_q[GRP_W-1:0];
  end

  a_fill_max: assert property (@(posedge px_clk_i) disable iff (!rst_n_i)
    fill_q <= GBX_FILL_W'(GBX_BUF_W));

  // Line lengths from the parser leave no residue behind a line end.
  a_line_empty: assert property (@(posedge px_clk_i) disable iff (!rst_n_i)
    grp_last_o |-> fill_q == '0);

endmodule

// ==== hw/raw10_unpacker.sv ====
`timescale 1ns/1ps

module raw10_unpacker (
  input  logic                        px_clk_i,
  input  logic                        rst_n_i,
  input  logic [pixel_pkg::GRP_W-1:0] grp_i,
  input  logic                        grp_valid_i,
  input  logic                        first_i,
  input  logic                        last_i,
  output pixel_pkg::pix_t             pix_o [pixel_pkg::PIX_PER_GRP],
  output logic                        pix_valid_o,
  output logic                        line_start_o,
  output logic                        line_end_o
);

  import pixel_pkg::*;

  localparam int LSB_BYTE = PIX_MSB_W * PIX_PER_GRP;  // Start of the shared low-bit byte.

  always_ff @(posedge px_clk_i)
  begin
    if (grp_valid_i)
    begin
      // Byte i is the top of pixel i, two bits of byte 4 complete it.
      for (int i = 0; i < PIX_PER_GRP; i++)
      begin
        pix_o[i] <= {grp_i[PIX_MSB_W*i +: PIX_MSB_W],
                     grp_i[LSB_BYTE + PIX_LSB_W*i +: PIX_LSB_W]};
      end
    end
  end

  always_ff @(posedge px_clk_i)
  begin
    if (!rst_n_i)
    begin
      pix_valid_o  <= 1'b0;
      line_start_o <= 1'b0;
      line_end_o   <= 1'b0;
    end
    else
    begin
      pix_valid_o  <= grp_valid_i;
      line_start_o <= grp_valid_i && first_i;
      line_end_o   <= grp_valid_i && last_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the CSI-2 receiver testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_csi2_rx -f verilog.f \
  --Mdir obj_dir -o sim_csi2_rx \
  && ./obj_dir/sim_csi2_rx | tee /dev/stderr | grep -qF "All tests passed!" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== verilog.f ====
+incdir+dv
hw/csi2_pkg.sv
hw/pixel_pkg.sv
hw/csi2_header_ecc.sv
hw/csi2_pkt_parser.sv
hw/raw10_gearbox.sv
hw/raw10_unpacker.sv
hw/csi2_rx_core.sv
dv/tb_csi2_rx.sv
